/* hdl/flash_pkg.sv */
/* Widths and constants for the serial flash prefetch path.
   Fast Read only, 24-bit byte addresses and 32-bit little-endian words. */

package flash_pkg;

    // Data path
    localparam int WORD_BITS = 32;               // One flash word
    localparam int ADDR_BITS = 24;               // Flash byte address

    // Fast Read transaction layout
    localparam logic [7:0] CMD_FAST_READ = 8'h0B;
    localparam int DUMMY_BITS = 8;               // Dummy clocks after the address
    localparam int HEADER_BITS = 8 + ADDR_BITS + DUMMY_BITS;   // 40 bits out on MOSI

    // Client request
    localparam int COUNT_BITS = 8;               // Words per start, 0 means nothing

    // Word buffer
    localparam int FIFO_DEPTH = 8;               // Must stay a power of two
    localparam int FIFO_LEVEL_BITS = 4;          // Holds 0 to FIFO_DEPTH

    typedef logic [WORD_BITS-1:0] word_t;

endpackage

/* hdl/spi_flash_reader.sv */
/* Single Fast Read per request; the SPI clock is the gated inverse of i_clock.
   Request must drop after o_ready before the next transaction can start. */

module spi_flash_reader (
    input  logic                          i_clock,
    input  logic                          i_arst_n,
    input  logic                          i_request,
    input  logic [flash_pkg::ADDR_BITS-1:0] i_address,
    output flash_pkg::word_t              o_rdata,
    output logic                          o_ready,
    output logic                          o_spi_cs_n,
    output logic                          o_spi_clk,
    output logic                          o_spi_mosi,
    input  logic                          i_spi_miso
);
    import flash_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETUP,
        ST_HEADER,
        ST_DATA,
        ST_WAIT_LOW
    } state_t;

    state_t                 state;
    logic [HEADER_BITS-1:0] shift_reg;       // Opcode, address, dummy, MSB first
    logic [5:0]             bit_cnt;         // Counts up to HEADER_BITS-1
    word_t                  rx_data;         // MISO bits in arrival order

    // First byte received is the lowest address, it goes to the low byte
    assign o_rdata = {rx_data[7:0], rx_data[15:8], rx_data[23:16], rx_data[31:24]};

    assign o_spi_clk  = ~o_spi_cs_n & ~i_clock;  // Rises mid-cycle, falls on i_clock rise
    assign o_spi_mosi = shift_reg[HEADER_BITS-1];

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= ST_IDLE;
            shift_reg  <= '0;
            bit_cnt    <= '0;
            o_ready    <= 1'b0;
            o_spi_cs_n <= 1'b1;
        end else begin
            o_ready <= 1'b0;                 // Single-cycle pulse
            case (state)
                ST_IDLE: begin
                    if (i_request) begin
                        shift_reg <= {CMD_FAST_READ, i_address, {DUMMY_BITS{1'b0}}};
                        state     <= ST_SETUP;
                    end
                end

                ST_SETUP: begin
                    o_spi_cs_n <= 1'b0;      // First bit already sits on MOSI
                    bit_cnt    <= '0;
                    state      <= ST_HEADER;
                end

                ST_HEADER: begin
                    shift_reg <= {shift_reg[HEADER_BITS-2:0], 1'b0};
                    bit_cnt   <= bit_cnt + 6'd1;
                    if (bit_cnt == 6'(HEADER_BITS - 1)) begin
                        bit_cnt <= '0;
                        state   <= ST_DATA;
                    end
                end

                ST_DATA: begin
                    bit_cnt <= bit_cnt + 6'd1;
                    if (bit_cnt == 6'(WORD_BITS - 1)) begin
                        o_spi_cs_n <= 1'b1;  // Ends the 72nd SPI clock
                        o_ready    <= 1'b1;
                        state      <= ST_WAIT_LOW;
                    end
                end

                ST_WAIT_LOW: begin
                    if (!i_request) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Sampled on the i_clock rise, the flash updates MISO on the same edge's
    // preceding SPI fall, so the bit has been stable for a full cycle
    always_ff @(posedge i_clock) begin
        if (state == ST_DATA) begin
            rx_data <= {rx_data[WORD_BITS-2:0], i_spi_miso};
        end
    end

endmodule

/* hdl/prefetch_sequencer.sv */
/* Walks a run of consecutive words, one reader request at a time.
   A start while busy is ignored; a zero count never raises busy. */

module prefetch_sequencer (
    input  logic                                i_clock,
    input  logic                                i_arst_n,
    input  logic                                i_start,
    input  logic [flash_pkg::ADDR_BITS-1:0]       i_base_addr,
    input  logic [flash_pkg::COUNT_BITS-1:0]      i_word_count,
    input  logic [flash_pkg::FIFO_LEVEL_BITS-1:0] i_level,
    input  logic                                i_ready,
    output logic                                o_request,
    output logic [flash_pkg::ADDR_BITS-1:0]       o_address,
    output logic                                o_busy
);
    import flash_pkg::*;

    logic [COUNT_BITS-1:0] remaining;        // Words still to be read
    logic                  fifo_room;

    // Only used while the request is low, so no word is in flight then
    assign fifo_room = i_level < FIFO_LEVEL_BITS'(FIFO_DEPTH);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_request <= 1'b0;
            o_address <= '0;
            o_busy    <= 1'b0;
            remaining <= '0;
        end else begin
            if (i_start && !o_busy) begin
                o_address <= i_base_addr;
                remaining <= i_word_count;
                o_busy    <= (i_word_count != '0);
            end else if (o_request) begin
                // Hold request and address until the reader returns the word
                if (i_ready) begin
                    o_request <= 1'b0;
                    o_address <= o_address + ADDR_BITS'(WORD_BITS / 8);
                    remaining <= remaining - COUNT_BITS'(1);
                    if (remaining == COUNT_BITS'(1)) begin
                        o_busy <= 1'b0;  // Last word is being pushed now
                    end
                end
            end else if (o_busy && fifo_room) begin
                o_request <= 1'b1;           // Level already counts the last push
            end
        end
    end

endmodule

/* hdl/word_fifo.sv */
/* Circular buffer of flash words, depth must be a power of two.
   Push while full and pop while empty are dropped. */

module word_fifo (
    input  logic                                i_clock,
    input  logic                                i_arst_n,
    input  logic                                i_push,
    input  flash_pkg::word_t                    i_data,
    input  logic                                i_pop,
    output flash_pkg::word_t                    o_data,
    output logic                                o_empty,
    output logic [flash_pkg::FIFO_LEVEL_BITS-1:0] o_level
);
    import flash_pkg::*;

    word_t                         mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;   // Wraps on its own
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic                          full;
    logic                          do_push;
    logic                          do_pop;

    assign o_empty = (o_level == '0);
    assign full    = (o_level == FIFO_LEVEL_BITS'(FIFO_DEPTH));
    assign do_push = i_push & ~full;
    assign do_pop  = i_pop & ~o_empty;
    assign o_data  = mem[rd_ptr];            // Head entry

    always_ff @(posedge i_clock) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_level <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   o_level <= o_level + 1'b1;
                2'b01:   o_level <= o_level - 1'b1;
                default: o_level <= o_level;     // Both or neither
            endcase
        end
    end

endmodule

/* hdl/flash_prefetch.sv */
/* Prefetches consecutive flash words into an 8-entry FIFO for the client.
   Pop only while o_empty is low; the first word arrives after a variable delay. */

module flash_prefetch (
    input  logic                           i_clock,
    input  logic                           i_arst_n,
    input  logic                           i_start,
    input  logic [flash_pkg::ADDR_BITS-1:0]  i_base_addr,
    input  logic [flash_pkg::COUNT_BITS-1:0] i_word_count,
    input  logic                           i_pop,
    output flash_pkg::word_t               o_word,
    output logic                           o_empty,
    output logic                           o_busy,
    output logic                           o_spi_cs_n,
    output logic                           o_spi_clk,
    output logic                           o_spi_mosi,
    input  logic                           i_spi_miso
);
    import flash_pkg::*;

    logic                       request;
    logic [ADDR_BITS-1:0]       address;
    logic                       ready;      // Also the FIFO push
    word_t                      rdata;
    logic [FIFO_LEVEL_BITS-1:0] level;

    prefetch_sequencer u_sequencer (
        .i_clock      (i_clock),
        .i_arst_n     (i_arst_n),
        .i_start      (i_start),
        .i_base_addr  (i_base_addr),
        .i_word_count (i_word_count),
        .i_level      (level),
        .i_ready      (ready),
        .o_request    (request),
        .o_address    (address),
        .o_busy       (o_busy)
    );

    spi_flash_reader u_reader (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_request  (request),
        .i_address  (address),
        .o_rdata    (rdata),
        .o_ready    (ready),
        .o_spi_cs_n (o_spi_cs_n),
        .o_spi_clk  (o_spi_clk),
        .o_spi_mosi (o_spi_mosi),
        .i_spi_miso (i_spi_miso)
    );

    word_fifo u_fifo (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_push   (ready),
        .i_data   (rdata),
        .i_pop    (i_pop),
        .o_data   (o_word),
        .o_empty  (o_empty),
        .o_level  (level)
    );

endmodule

/* tb/spi_flash_model.sv */
/* Serial flash that answers Fast Read only, byte at address a is a[7:0] ^ 0x5A.
   Sends 32 data bits per transaction, then drives zero. */

module spi_flash_model (
    input  logic i_spi_cs_n,
    input  logic i_spi_clk,
    input  logic i_spi_mosi,
    output logic o_spi_miso
);
    int unsigned bit_cnt;                    // SPI rising edges since cs_n fell
    logic [39:0] header;                     // Opcode, address, dummy
    logic [23:0] addr;
    int unsigned data_idx;
    logic [7:0]  data_byte;

    initial begin
        bit_cnt    = 0;
        header     = '0;
        o_spi_miso = 1'b0;
    end

    // Sample MOSI on the rising SPI clock
    always @(posedge i_spi_clk or posedge i_spi_cs_n) begin
        if (i_spi_cs_n) begin
            bit_cnt = 0;
        end else begin
            if (bit_cnt < 40) begin
                header = {header[38:0], i_spi_mosi};
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    // Update MISO on the falling SPI clock, MSB of each byte first
    always @(negedge i_spi_clk) begin
        if (bit_cnt >= 40 && bit_cnt < 72) begin
            data_idx   = bit_cnt - 40;
            addr       = header[31:8] + 24'(data_idx / 8);
            data_byte  = addr[7:0] ^ 8'h5A;
            o_spi_miso <= data_byte[7 - (data_idx % 8)];
        end else begin
            o_spi_miso <= 1'b0;
        end
    end

endmodule

/* tb/flash_prefetch_props.sv */
/* Checks bound to flash_prefetch; expected addresses reload on every accepted start.
   fail_count is read by the testbench at the end of the run. */

module flash_prefetch_props (
    input  logic                                  i_clock,
    input  logic                                  i_arst_n,
    input  logic                                  i_start,
    input  logic [flash_pkg::ADDR_BITS-1:0]       i_base_addr,
    input  logic                                  i_pop,
    input  flash_pkg::word_t                      o_word,
    input  logic                                  o_empty,
    input  logic                                  o_busy,
    input  logic                                  o_spi_cs_n,
    input  logic                                  o_spi_clk,
    input  logic                                  o_spi_mosi,
    input  logic [flash_pkg::FIFO_LEVEL_BITS-1:0] i_level,
    input  logic                                  i_ready
);
    import flash_pkg::*;

    int unsigned          fail_count = 0;
    int unsigned          total = 0;         // SPI clock pulses since time zero
    int unsigned          win_start;         // Pulse count when cs_n last was high
    logic [31:0]          hdr;               // Opcode and address seen on MOSI
    logic [ADDR_BITS-1:0] rd_addr;           // Address of the next transaction
    logic [ADDR_BITS-1:0] pop_addr;          // Address of the next popped word
    logic                 cs_prev;

    // Bytes a..a+3 with the lowest address in the low byte
    function automatic word_t expect_word(input logic [ADDR_BITS-1:0] a);
        word_t                w;
        logic [ADDR_BITS-1:0] b;
        for (int k = 0; k < 4; k++) begin
            b           = a + ADDR_BITS'(k);
            w[8*k +: 8] = b[7:0] ^ 8'h5A;
        end
        return w;
    endfunction

    always @(posedge o_spi_clk) begin
        if (total - win_start < 32) begin
            hdr <= {hdr[30:0], o_spi_mosi};
        end
        total <= total + 1;
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_addr   <= '0;
            pop_addr  <= '0;
            cs_prev   <= 1'b1;
            win_start <= total;
        end else begin
            cs_prev <= o_spi_cs_n;
            if (o_spi_cs_n) begin
                win_start <= total;
            end
            if (i_start && !o_busy) begin
                rd_addr  <= i_base_addr;
                pop_addr <= i_base_addr;
            end else begin
                if (o_spi_cs_n && !cs_prev) begin
                    rd_addr <= rd_addr + ADDR_BITS'(4);
                end
                if (i_pop && !o_empty) begin
                    pop_addr <= pop_addr + ADDR_BITS'(4);
                end
            end
        end
    end

    a_reset: assert property (@(posedge i_clock)
        $rose(i_arst_n) |-> o_spi_cs_n && o_empty && !o_busy)
        else begin
            $error("** Error @%0t: outputs not idle after reset", $time);
            fail_count++;
        end

    a_idle_clk: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        o_spi_cs_n && $past(o_spi_cs_n) |-> total == $past(total))
        else begin
            $error("** Error @%0t: SPI clock pulse with cs_n high", $time);
            fail_count++;
        end

    a_pulses: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(o_spi_cs_n) |-> total - win_start == 72)
        else begin
            $error("** Error @%0t: wrong SPI pulse count", $time);
            fail_count++;
        end

    a_header: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        $rose(o_spi_cs_n) |-> hdr == {CMD_FAST_READ, rd_addr})
        else begin
            $error("** Error @%0t: wrong command or address", $time);
            fail_count++;
        end

    a_pop: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_pop && !o_empty |-> o_word == expect_word(pop_addr))
        else begin
            $error("** Error @%0t: popped word mismatch", $time);
            fail_count++;
        end

    a_full: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_level == FIFO_LEVEL_BITS'(FIFO_DEPTH) |-> o_spi_cs_n)
        else begin
            $error("** Error @%0t: transfer while FIFO full", $time);
            fail_count++;
        end

    a_room: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_ready |-> i_level < FIFO_LEVEL_BITS'(FIFO_DEPTH))
        else begin
            $error("** Error @%0t: push into full FIFO", $time);
            fail_count++;
        end

endmodule

bind flash_prefetch flash_prefetch_props u_props (
    .i_clock     (i_clock),
    .i_arst_n    (i_arst_n),
    .i_start     (i_start),
    .i_base_addr (i_base_addr),
    .i_pop       (i_pop),
    .o_word      (o_word),
    .o_empty     (o_empty),
    .o_busy      (o_busy),
    .o_spi_cs_n  (o_spi_cs_n),
    .o_spi_clk   (o_spi_clk),
    .o_spi_mosi  (o_spi_mosi),
    .i_level     (level),
    .i_ready     (ready)
);

/* tb/tb_flash_prefetch.sv */
/* Random streams, a zero count and a back-pressure phase.
   Word and SPI checks live in the bound assertions. */

module tb_flash_prefetch;
    import flash_pkg::*;

    localparam int LIMIT = 3000;             // Cycles per wait loop

    logic                  i_clock = 1'b0;
    logic                  i_arst_n = 1'b0;
    logic                  i_start = 1'b0;
    logic [ADDR_BITS-1:0]  i_base_addr = '0;
    logic [COUNT_BITS-1:0] i_word_count = '0;
    logic                  i_pop = 1'b0;
    word_t                 o_word;
    logic                  o_empty, o_busy, o_spi_cs_n, o_spi_clk, o_spi_mosi, i_spi_miso;
    int unsigned           errors = 0;
    int unsigned           pops = 0;         // Pops honored by the FIFO

    flash_prefetch u_flash_prefetch (.*);

    spi_flash_model u_flash (
        .i_spi_cs_n (o_spi_cs_n),
        .i_spi_clk  (o_spi_clk),
        .i_spi_mosi (o_spi_mosi),
        .o_spi_miso (i_spi_miso)
    );

    always #2 i_clock = ~i_clock;

    // The FIFO takes this pop on the next rising edge
    always @(negedge i_clock) begin
        if (i_pop && !o_empty) begin
            pops++;
        end
    end

    task automatic start_stream(input logic [ADDR_BITS-1:0] base, input int count);
        @(posedge i_clock);
        i_start      <= 1'b1;
        i_base_addr  <= base;
        i_word_count <= COUNT_BITS'(count);
        @(posedge i_clock);
        i_start <= 1'b0;
    endtask

    // Waits for a word and then pops it once
    task automatic pop_one();
        int n;
        n = 0;
        @(negedge i_clock);
        while (o_empty && n < LIMIT) begin
            @(negedge i_clock);
            n++;
        end
        if (o_empty) begin
            $display("Timeout waiting for a word in the FIFO");
            errors++;
        end else begin
            @(posedge i_clock);
            i_pop <= 1'b1;
            @(posedge i_clock);
            i_pop <= 1'b0;
        end
    endtask

    task automatic wait_transactions(input int count);
        int n;
        int seen;
        logic prev;
        n    = 0;
        seen = 0;
        prev = o_spi_cs_n;
        while (seen < count && n < LIMIT * count) begin
            @(negedge i_clock);
            if (o_spi_cs_n && !prev) seen++;
            prev = o_spi_cs_n;
            n++;
        end
        if (seen < count) begin
            $display("Timeout waiting for %0d SPI transactions", count);
            errors++;
        end
    endtask

    // cs_n must stay high and the FIFO non-empty for a while
    task automatic watch_held(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge i_clock);
            if (!o_spi_cs_n || o_empty) begin
                $display("** Error @%0t: flash access or empty FIFO during back-pressure", $time);
                errors++;
                break;
            end
        end
    endtask

    task automatic check_done(input int count);
        int n;
        n = 0;
        @(negedge i_clock);
        while (o_busy && n < LIMIT) begin
            @(negedge i_clock);
            n++;
        end
        if (o_busy) begin
            $display("Timeout waiting for o_busy to fall");
            errors++;
        end else if (!o_empty || pops != count) begin
            $display("** Error @%0t: end state wrong, %0d pops for %0d words", $time, pops, count);
            errors++;
        end
    endtask

    task automatic run_stream(input int count);
        int gap;
        pops = 0;
        start_stream(24'($urandom), count);
        for (int i = 0; i < count; i++) begin
            gap = $urandom % 4;
            repeat (gap) @(posedge i_clock);
            pop_one();
        end
        check_done(count);
    endtask

    initial begin
        void'($urandom(32'h773e_4c5b));
        repeat (2) @(posedge i_clock);
        i_arst_n <= 1'b1;
        repeat (4) @(posedge i_clock);

        // Zero count gives no flash access at all
        pops = 0;
        start_stream(24'($urandom), 0);
        for (int i = 0; i < 100; i++) begin
            @(negedge i_clock);
            if (!o_spi_cs_n || o_busy) begin
                $display("** Error @%0t: activity after a zero count start", $time);
                errors++;
                break;
            end
        end

        for (int s = 0; s < 3; s++) begin
            run_stream(1 + $urandom % 20);
        end

        // Back-pressure with no pops until the FIFO is full
        pops = 0;
        start_stream(24'($urandom), 12);
        wait_transactions(8);
        watch_held(200);
        pop_one();
        wait_transactions(1);
        watch_held(200);
        for (int i = 1; i < 12; i++) begin
            pop_one();
        end
        check_done(12);

        $display("Errors: testbench %0d, assertions %0d", errors,
                 u_flash_prefetch.u_props.fail_count);
        if (errors == 0 && u_flash_prefetch.u_props.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/flash_pkg.sv
hdl/spi_flash_reader.sv
hdl/prefetch_sequencer.sv
hdl/word_fifo.sv
hdl/flash_prefetch.sv
tb/spi_flash_model.sv
tb/flash_prefetch_props.sv
tb/tb_flash_prefetch.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the flash prefetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module tb_flash_prefetch -Mdir obj_dir -o sim_flash_prefetch

./obj_dir/sim_flash_prefetch > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
else
    exit 1
fi
